// File: design/ahb_addr_decoder.sv
/*
 * Address decoder for one master port
 * Purely combinational, zero cycles
 * Ranges come from the config header and are inclusive at both ends
 * Any non-IDLE transfer outside the map selects the default slave
 */
`timescale 1ns/10ps
`include "ahb_config.svh"

module ahb_addr_decoder (
  input  ahb_pkg::addr_t         haddr,
  input  ahb_pkg::htrans_t       htrans,
  output logic [`AHB_SLAVES-1:0] hreq,
  output logic                   default_sel
);

  import ahb_pkg::*;

  // ==========================================================
  // Address map
  // ==========================================================
  addr_t                  lo_addr [`AHB_SLAVES];
  addr_t                  hi_addr [`AHB_SLAVES];
  logic [`AHB_SLAVES-1:0] slave_hit;
  logic                   xfer_active;

  // Slave 0 window
  assign lo_addr[0] = `SLV0_LO;
  assign hi_addr[0] = `SLV0_HI;
  // Slave 1 window
  assign lo_addr[1] = `SLV1_LO;
  assign hi_addr[1] = `SLV1_HI;

  // ==========================================================
  // Range compare
  // ==========================================================
  for (genvar i = 0; i < `AHB_SLAVES; i++) begin : g_hit
    // Full address, both bounds included
    assign slave_hit[i] = (haddr >= lo_addr[i]) && (haddr <= hi_addr[i]);
  end

  // Anything but IDLE counts as a transfer
  assign xfer_active = (htrans != IDLE);

  assign hreq = xfer_active ? slave_hit : '0;

  // Unmapped access goes to the error responder
  assign default_sel = xfer_active & ~|slave_hit;

endmodule

// File: design/ahb_config.svh
/*
 * Widths, fabric size and address map of the two-master AHB-lite fabric
 * Slave ranges are inclusive on the full address and must not overlap
 * Each SRAM range should span SRAM_WORDS words or wrap will alias words
 */
`ifndef AHB_CONFIG_SVH
`define AHB_CONFIG_SVH

// Bus widths
`define AHB_ADDR_W 32
`define AHB_DATA_W 32

// Fabric size, arbiter logic assumes two masters
`define AHB_MASTERS 2
`define AHB_SLAVES  2

// Address map
`define SLV0_LO 32'h0000_0000
`define SLV0_HI 32'h0000_03FF
`define SLV1_LO 32'h0000_0400
`define SLV1_HI 32'h0000_07FF

// Words per SRAM slave
`define SRAM_WORDS 256

`endif

// File: design/ahb_default_slave.sv
/*
 * Error responder for one master port
 * Gives the two-cycle ERROR response to any accepted unmapped access
 * First cycle holds hready low, second releases it
 */
`timescale 1ns/10ps

module ahb_default_slave (
  input  logic            hclk,
  input  logic            rst,
  input  logic            default_sel,
  input  logic            hready_in,
  output logic            hready,
  output ahb_pkg::hresp_t hresp
);

  import ahb_pkg::*;

  typedef enum logic [1:0] {
    ST_OKAY,
    ST_ERR1,
    ST_ERR2
  } state_t;

  state_t state;

  // Address phase accepted into the unmapped region
  always_ff @(posedge hclk) begin
    if (rst) begin
      state <= ST_OKAY;
    end else begin
      case (state)
        ST_ERR1: state <= ST_ERR2;
        default: state <= (default_sel && hready_in) ? ST_ERR1 : ST_OKAY;
      endcase
    end
  end

  // Stall only in the first error cycle
  assign hready = (state != ST_ERR1);
  assign hresp  = (state == ST_OKAY) ? OKAY : ERROR;

endmodule

// File: design/ahb_interconnect_top.sv
/*
 * Two-master, two-slave AHB-lite interconnect
 * Each master has its own decoder and error responder
 * Each SRAM slave sits behind a round-robin arbiter
 * Masters must not issue a new address phase before the data phase ends
 */
`timescale 1ns/10ps
`include "ahb_config.svh"

module ahb_interconnect_top (
  input  logic             hclk,
  input  logic             rst,
  // Master 0 port
  input  ahb_pkg::addr_t   m0_haddr,
  input  ahb_pkg::htrans_t m0_htrans,
  input  logic             m0_hwrite,
  input  ahb_pkg::data_t   m0_hwdata,
  output logic             m0_hready,
  output ahb_pkg::data_t   m0_hrdata,
  output ahb_pkg::hresp_t  m0_hresp,
  // Master 1 port
  input  ahb_pkg::addr_t   m1_haddr,
  input  ahb_pkg::htrans_t m1_htrans,
  input  logic             m1_hwrite,
  input  ahb_pkg::data_t   m1_hwdata,
  output logic             m1_hready,
  output ahb_pkg::data_t   m1_hrdata,
  output ahb_pkg::hresp_t  m1_hresp
);

  import ahb_pkg::*;

  // ==========================================================
  // Master side
  // ==========================================================
  addr_t                  m_haddr  [`AHB_MASTERS];
  htrans_t                m_htrans [`AHB_MASTERS];
  logic                   m_hwrite [`AHB_MASTERS];
  data_t                  m_hwdata [`AHB_MASTERS];
  logic                   m_hready [`AHB_MASTERS];
  data_t                  m_hrdata [`AHB_MASTERS];
  hresp_t                 m_hresp  [`AHB_MASTERS];
  logic [`AHB_SLAVES-1:0] m_hreq   [`AHB_MASTERS];
  logic                   m_dsel   [`AHB_MASTERS];
  logic                   m_dready [`AHB_MASTERS];

  // Slave side
  logic [`AHB_MASTERS-1:0] s_hreq   [`AHB_SLAVES];
  logic [`AHB_MASTERS-1:0] s_grant  [`AHB_SLAVES];
  logic [`AHB_MASTERS-1:0] s_owner  [`AHB_SLAVES];
  addr_t                   s_haddr  [`AHB_SLAVES];
  htrans_t                 s_htrans [`AHB_SLAVES];
  logic                    s_hwrite [`AHB_SLAVES];
  data_t                   s_hwdata [`AHB_SLAVES];
  data_t                   s_hrdata [`AHB_SLAVES];
  data_t                   s_rdata  [`AHB_SLAVES];

  // Flatten the loose ports
  assign m_haddr[0]  = m0_haddr;
  assign m_htrans[0] = m0_htrans;
  assign m_hwrite[0] = m0_hwrite;
  assign m_hwdata[0] = m0_hwdata;
  assign m_haddr[1]  = m1_haddr;
  assign m_htrans[1] = m1_htrans;
  assign m_hwrite[1] = m1_hwrite;
  assign m_hwdata[1] = m1_hwdata;

  assign m0_hready = m_hready[0];
  assign m0_hrdata = m_hrdata[0];
  assign m0_hresp  = m_hresp[0];
  assign m1_hready = m_hready[1];
  assign m1_hrdata = m_hrdata[1];
  assign m1_hresp  = m_hresp[1];

  // ==========================================================
  // Per master path
  // ==========================================================
  for (genvar m = 0; m < `AHB_MASTERS; m++) begin : g_master
    logic  stall;
    data_t rdata_sel;

    ahb_addr_decoder u_dec (
      .haddr       (m_haddr[m]),
      .htrans      (m_htrans[m]),
      .hreq        (m_hreq[m]),
      .default_sel (m_dsel[m])
    );

    ahb_default_slave u_dslv (
      .hclk        (hclk),
      .rst         (rst),
      .default_sel (m_dsel[m]),
      .hready_in   (m_hready[m]),
      .hready      (m_dready[m]),
      .hresp       (m_hresp[m])
    );

    // Stall on a request that lost arbitration, read data from the owning slave
    always_comb begin
      stall     = 1'b0;
      rdata_sel = '0;
      for (int s = 0; s < `AHB_SLAVES; s++) begin
        if (m_hreq[m][s] && !s_grant[s][m]) begin
          stall = 1'b1;
        end
        if (s_owner[s][m]) begin
          rdata_sel = s_rdata[s];
        end
      end
    end

    assign m_hready[m] = m_dready[m] & ~stall;
    assign m_hrdata[m] = rdata_sel;
  end

  // ==========================================================
  // Per slave path
  // ==========================================================
  for (genvar s = 0; s < `AHB_SLAVES; s++) begin : g_slave
    // Requests seen from this slave
    for (genvar m = 0; m < `AHB_MASTERS; m++) begin : g_req
      assign s_hreq[s][m] = m_hreq[m][s];
    end

    ahb_slave_arbiter u_arb (
      .hclk        (hclk),
      .rst         (rst),
      .hreq        (s_hreq[s]),
      .m_haddr     (m_haddr),
      .m_htrans    (m_htrans),
      .m_hwrite    (m_hwrite),
      .m_hwdata    (m_hwdata),
      .s_hrdata    (s_hrdata[s]),
      .grant       (s_grant[s]),
      .s_haddr     (s_haddr[s]),
      .s_htrans    (s_htrans[s]),
      .s_hwrite    (s_hwrite[s]),
      .s_hwdata    (s_hwdata[s]),
      .owner_valid (s_owner[s]),
      .hrdata      (s_rdata[s])
    );

    ahb_sram_slave #(
      .DEPTH (`SRAM_WORDS)
    ) u_sram (
      .hclk   (hclk),
      .rst    (rst),
      .haddr  (s_haddr[s]),
      .htrans (s_htrans[s]),
      .hwrite (s_hwrite[s]),
      .hwdata (s_hwdata[s]),
      .hrdata (s_hrdata[s])
    );
  end

endmodule

// File: design/ahb_pkg.sv
/*
 * Shared AHB-lite types for the interconnect
 * Only single-beat word transfers are supported
 * BUSY and SEQ are kept for encoding and behave like NONSEQ
 */
`include "ahb_config.svh"

package ahb_pkg;

  // Transfer type, standard AHB encoding
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_t;

  // Slave response, no split or retry
  typedef enum logic {
    OKAY  = 1'b0,
    ERROR = 1'b1
  } hresp_t;

  // Address and data words
  typedef logic [`AHB_ADDR_W-1:0] addr_t;
  typedef logic [`AHB_DATA_W-1:0] data_t;

endpackage

// File: design/ahb_slave_arbiter.sv
/*
 * Two-master round-robin arbiter in front of one slave
 * Grant is combinational in the address phase, owner registered for data phase
 * Master 0 has priority after reset
 * Assumes non-pipelined masters and a zero-wait slave
 */
`timescale 1ns/10ps
`include "ahb_config.svh"

module ahb_slave_arbiter (
  input  logic                    hclk,
  input  logic                    rst,
  input  logic [`AHB_MASTERS-1:0] hreq,
  input  ahb_pkg::addr_t          m_haddr  [`AHB_MASTERS],
  input  ahb_pkg::htrans_t        m_htrans [`AHB_MASTERS],
  input  logic                    m_hwrite [`AHB_MASTERS],
  input  ahb_pkg::data_t          m_hwdata [`AHB_MASTERS],
  input  ahb_pkg::data_t          s_hrdata,
  output logic [`AHB_MASTERS-1:0] grant,
  output ahb_pkg::addr_t          s_haddr,
  output ahb_pkg::htrans_t        s_htrans,
  output logic                    s_hwrite,
  output ahb_pkg::data_t          s_hwdata,
  output logic [`AHB_MASTERS-1:0] owner_valid,
  output ahb_pkg::data_t          hrdata
);

  import ahb_pkg::*;

  logic                    last_win;   // index of last granted master
  logic                    win_idx;
  logic                    owner_idx;
  logic [`AHB_MASTERS-1:0] owner_q;

  // ==========================================================
  // Round robin pick
  // ==========================================================
  always_comb begin
    grant   = '0;
    win_idx = 1'b0;
    if (hreq[0] && hreq[1]) begin
      // Contention, the one that lost last time wins
      win_idx = ~last_win;
    end else if (hreq[1]) begin
      win_idx = 1'b1;
    end
    if (|hreq) begin
      grant[win_idx] = 1'b1;
    end
  end

  // Address phase to the slave
  assign s_haddr  = m_haddr[win_idx];
  assign s_htrans = (|hreq) ? m_htrans[win_idx] : IDLE;
  assign s_hwrite = m_hwrite[win_idx];

  // ==========================================================
  // Data phase owner
  // ==========================================================
  always_ff @(posedge hclk) begin
    if (rst) begin
      last_win <= 1'b1;
      owner_q  <= '0;
    end else begin
      owner_q <= grant;
      // Only a granted transfer moves the pointer
      if (|hreq) begin
        last_win <= win_idx;
      end
    end
  end

  // One-hot owner back to an index
  assign owner_idx = owner_q[1];

  // Write data follows the owner, not the current winner
  assign s_hwdata    = m_hwdata[owner_idx];
  assign owner_valid = owner_q;
  assign hrdata      = (|owner_q) ? s_hrdata : '0;

endmodule

// File: design/ahb_sram_slave.sv
/*
 * Zero-wait word SRAM behind an AHB-lite slave port
 * Full-word accesses only, hsize is not looked at
 * Word index is the address above the byte offset, modulo DEPTH
 * Contents are undefined until written
 */
`timescale 1ns/10ps
`include "ahb_config.svh"

module ahb_sram_slave #(
  parameter int DEPTH = `SRAM_WORDS
) (
  input  logic             hclk,
  input  logic             rst,
  input  ahb_pkg::addr_t   haddr,
  input  ahb_pkg::htrans_t htrans,
  input  logic             hwrite,
  input  ahb_pkg::data_t   hwdata,
  output ahb_pkg::data_t   hrdata
);

  import ahb_pkg::*;

  localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  data_t            mem [DEPTH];
  addr_t            word_addr;
  logic [IDX_W-1:0] idx_q;
  logic             write_q;
  logic             valid_q;

  // Drop byte offset, wrap into the array
  assign word_addr = (haddr >> 2) % DEPTH;

  // ==========================================================
  // Address phase capture
  // ==========================================================
  always_ff @(posedge hclk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= (htrans != IDLE);
    end
  end

  always_ff @(posedge hclk) begin
    if (htrans != IDLE) begin
      idx_q   <= word_addr[IDX_W-1:0];
      write_q <= hwrite;
    end
  end

  // ==========================================================
  // Data phase
  // ==========================================================
  always_ff @(posedge hclk) begin
    if (valid_q && write_q) begin
      mem[idx_q] <= hwdata;
    end
  end

  // Read word valid through the whole data phase
  assign hrdata = (valid_q && !write_q) ? mem[idx_q] : '0;

endmodule

// File: project.f
+incdir+design
design/ahb_pkg.sv
design/ahb_addr_decoder.sv
design/ahb_slave_arbiter.sv
design/ahb_sram_slave.sv
design/ahb_default_slave.sv
design/ahb_interconnect_top.sv
test/tb_ahb_interconnect.sv

// File: test/ahb_vectors.txt
// m0: op addr wdata exp_rdata exp_resp | m1: op addr wdata exp_rdata exp_resp
// op 0 none, 1 read, 2 write; resp 0 OKAY, 1 ERROR; all fields hex
2 00000010 11111111 00000000 0  0 00000000 00000000 00000000 0
1 00000010 00000000 11111111 0  0 00000000 00000000 00000000 0
0 00000000 00000000 00000000 0  2 00000020 22222222 00000000 0
0 00000000 00000000 00000000 0  1 00000020 00000000 22222222 0
2 00000410 33333333 00000000 0  0 00000000 00000000 00000000 0
1 00000410 00000000 33333333 0  0 00000000 00000000 00000000 0
0 00000000 00000000 00000000 0  2 00000420 44444444 00000000 0
0 00000000 00000000 00000000 0  1 00000420 00000000 44444444 0
2 00000800 deadbeef 00000000 1  1 00001000 00000000 00000000 1
1 fffffffc 00000000 00000000 1  2 00000804 cafef00d 00000000 1
1 00000010 00000000 11111111 0  1 00000420 00000000 44444444 0
2 00000100 55555555 00000000 0  2 00000500 66666666 00000000 0
1 00000500 00000000 66666666 0  1 00000100 00000000 55555555 0
2 00000200 77777777 00000000 0  2 00000204 88888888 00000000 0
1 00000204 00000000 88888888 0  1 00000200 00000000 77777777 0
2 000007fc 9999aaaa 00000000 0  2 000003fc bbbbcccc 00000000 0
2 00000000 a5a5a5a5 00000000 0  2 00000400 5a5a5a5a 00000000 0
1 000003fc 00000000 bbbbcccc 0  1 000007fc 00000000 9999aaaa 0
1 00000400 00000000 5a5a5a5a 0  1 00000000 00000000 a5a5a5a5 0
1 00000010 00000000 11111111 0  1 00000410 00000000 33333333 0
1 00000020 00000000 22222222 0  1 00000020 00000000 22222222 0
0 00000000 00000000 00000000 0  0 00000000 00000000 00000000 0

// File: test/tb_ahb_interconnect.sv
/*
 * Testbench for the two-master AHB-lite interconnect
 * Replays test/ahb_vectors.txt, ten hex fields per step, NUM_STEPS steps
 * Run from the project root so the vector path resolves
 * Inputs change on the rising edge, outputs are sampled on the falling edge
 */
`timescale 1ns/10ps
`include "ahb_config.svh"

module tb_ahb_interconnect;

  import ahb_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int NUM_STEPS  = 22;
  localparam int FIELDS     = 10;
  // Op codes used in the vector file
  localparam int OP_NONE  = 0;
  localparam int OP_READ  = 1;
  localparam int OP_WRITE = 2;

  logic    hclk;
  logic    rst;
  addr_t   m0_haddr, m1_haddr;
  htrans_t m0_htrans, m1_htrans;
  logic    m0_hwrite, m1_hwrite;
  data_t   m0_hwdata, m1_hwdata;
  logic    m0_hready, m1_hready;
  data_t   m0_hrdata, m1_hrdata;
  hresp_t  m0_hresp, m1_hresp;

  logic [31:0] vec_mem [NUM_STEPS*FIELDS];
  int          n_checks;
  int          n_errors;
  // Address phase cycles spent with hready low, per master
  int          addr_waits [2];

  ahb_interconnect_top u_dut (
    .hclk      (hclk),
    .rst       (rst),
    .m0_haddr  (m0_haddr),
    .m0_htrans (m0_htrans),
    .m0_hwrite (m0_hwrite),
    .m0_hwdata (m0_hwdata),
    .m0_hready (m0_hready),
    .m0_hrdata (m0_hrdata),
    .m0_hresp  (m0_hresp),
    .m1_haddr  (m1_haddr),
    .m1_htrans (m1_htrans),
    .m1_hwrite (m1_hwrite),
    .m1_hwdata (m1_hwdata),
    .m1_hready (m1_hready),
    .m1_hrdata (m1_hrdata),
    .m1_hresp  (m1_hresp)
  );

  // ==========================================================
  // Clock and watchdog
  // ==========================================================
  always #(CLK_PERIOD/2) hclk = ~hclk;

  // Budget of 20 cycles per step
  initial begin
    #(NUM_STEPS * 20 * CLK_PERIOD);
    $display("Timeout: the vector replay did not finish in the allowed time");
    $display("Test failures found");
    $finish;
  end

  // ==========================================================
  // Helpers
  // ==========================================================
  task automatic compare(input string name, input logic [31:0] act, input logic [31:0] exp);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("[ERROR] %s got 0x%08h expected 0x%08h", name, act, exp);
    end
  endtask

  // Address phase drive for one master
  task automatic drive_addr(input int m, input htrans_t tr, input addr_t a, input logic wr);
    if (m == 0) begin
      m0_htrans <= tr;
      m0_haddr  <= a;
      m0_hwrite <= wr;
    end else begin
      m1_htrans <= tr;
      m1_haddr  <= a;
      m1_hwrite <= wr;
    end
  endtask

  task automatic drive_wdata(input int m, input data_t d);
    if (m == 0) m0_hwdata <= d;
    else m1_hwdata <= d;
  endtask

  function automatic logic [31:0] sample_out(input int m, input int which);
    // 0 hready, 1 hresp, 2 hrdata
    case (which)
      0:       return (m == 0) ? 32'(m0_hready) : 32'(m1_hready);
      1:       return (m == 0) ? 32'(m0_hresp) : 32'(m1_hresp);
      default: return (m == 0) ? m0_hrdata : m1_hrdata;
    endcase
  endfunction

  // Slave index from the address map, -1 when unmapped
  function automatic int slave_of(input addr_t a);
    if (a >= `SLV0_LO && a <= `SLV0_HI) begin
      return 0;
    end else if (a >= `SLV1_LO && a <= `SLV1_HI) begin
      return 1;
    end
    return -1;
  endfunction

  // One transfer on one master, fields start at base
  task automatic run_master(input int m, input int base);
    int    op;
    int    cycles;
    addr_t a;
    data_t wd;
    op = vec_mem[base];
    a  = vec_mem[base+1];
    wd = vec_mem[base+2];
    addr_waits[m] = 0;
    if (op != OP_NONE) begin
      @(posedge hclk);
      drive_addr(m, NONSEQ, a, op == OP_WRITE);
      // Held until a rising edge with hready high
      @(negedge hclk);
      while (sample_out(m, 0) != 1) begin
        addr_waits[m]++;
        @(negedge hclk);
      end
      @(posedge hclk);
      drive_addr(m, IDLE, a, 1'b0);
      drive_wdata(m, wd);
      cycles = 0;
      do begin
        @(negedge hclk);
        cycles++;
      end while (sample_out(m, 0) != 1);
      compare($sformatf("m%0d_hresp", m), sample_out(m, 1), vec_mem[base+4]);
      // SRAM ends in one data cycle, an unmapped address in two
      compare($sformatf("m%0d_data_cycles", m), cycles, vec_mem[base+4] ? 2 : 1);
      if (op == OP_READ && vec_mem[base+4] == 0) begin
        compare($sformatf("m%0d_hrdata", m), sample_out(m, 2), vec_mem[base+3]);
      end
      @(posedge hclk);
    end
  endtask

  // ==========================================================
  // Main sequence
  // ==========================================================
  initial begin
    int   gap;
    logic shared;
    hclk      = 1'b0;
    rst       = 1'b1;
    m0_haddr  = '0;
    m0_htrans = IDLE;
    m0_hwrite = 1'b0;
    m0_hwdata = '0;
    m1_haddr  = '0;
    m1_htrans = IDLE;
    m1_hwrite = 1'b0;
    m1_hwdata = '0;
    n_checks  = 0;
    n_errors  = 0;
    void'($urandom(32'h31af_7b92));
    $readmemh("test/ahb_vectors.txt", vec_mem);
    if (vec_mem[NUM_STEPS*FIELDS-1] === 'x) begin
      n_errors++;
      $display("The vector file holds fewer steps than the testbench expects");
    end

    repeat (4) @(posedge hclk);
    rst <= 1'b0;

    // Idle state straight after reset
    @(negedge hclk);
    compare("m0_hready", m0_hready, 1);
    compare("m1_hready", m1_hready, 1);
    compare("m0_hresp", m0_hresp, OKAY);
    compare("m1_hresp", m1_hresp, OKAY);

    for (int s = 0; s < NUM_STEPS; s++) begin
      // Random idle gap with junk on the unused buses
      gap = $urandom % 3;
      repeat (gap) begin
        @(posedge hclk);
        m0_haddr  <= $urandom;
        m0_hwdata <= $urandom;
        m1_haddr  <= $urandom;
        m1_hwdata <= $urandom;
      end
      fork
        run_master(0, s*FIELDS);
        run_master(1, s*FIELDS + 5);
      join
      // Same slave in one step costs the loser one stall cycle, else none
      shared = vec_mem[s*FIELDS] != OP_NONE && vec_mem[s*FIELDS + 5] != OP_NONE &&
               slave_of(vec_mem[s*FIELDS + 1]) >= 0 &&
               slave_of(vec_mem[s*FIELDS + 1]) == slave_of(vec_mem[s*FIELDS + 6]);
      compare("addr_wait_cycles", addr_waits[0] + addr_waits[1], shared ? 1 : 0);
    end

    repeat (2) @(posedge hclk);
    $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
